//--- Bender.yml
package:
  name: fpu_noncomp

export_include_dirs:
  - include

sources:
  - source/fpu_noncomp_pkg.sv
  - source/fpu_operand_class.sv
  - source/fpu_decode_stage.sv
  - source/fpu_exec_stage.sv
  - source/fpu_noncomp_unit.sv
  - target: test
    files:
      - verif/fpu_noncomp_checker.sv
      - verif/fpu_noncomp_props.sv
      - verif/fpu_noncomp_tb.sv

//--- filelist.f
+incdir+include
source/fpu_noncomp_pkg.sv
source/fpu_operand_class.sv
source/fpu_decode_stage.sv
source/fpu_exec_stage.sv
source/fpu_noncomp_unit.sv
verif/fpu_noncomp_checker.sv
verif/fpu_noncomp_props.sv
verif/fpu_noncomp_tb.sv

//--- include/fpu_params.svh
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// register file width, values are NaN-boxed singles
`define FPU_FLEN 64
`define FPU_SP_W 32

// tag carried alongside each operation
`define FPU_SCHED_IDX_W 3
`define FPU_RNID_W 6

// flags ordered NV, DZ, OF, UF, NX from msb
`define FPU_FFLAGS_W 5

// fclass one-hot mask
`define FPU_CLASS_W 10

`define FPU_CANON_NAN 32'h7fc00000

`endif

//--- source/fpu_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fpu_decode_stage
  import fpu_noncomp_pkg::*;
(
  input  wire logic                        i_clk,
  input  wire logic                        i_rst_n,
  input  wire logic                        i_valid,
  input  wire fpu_op_e                     i_op,
  input  wire logic [`FPU_FLEN-1:0]        i_rs1,
  input  wire logic [`FPU_FLEN-1:0]        i_rs2,
  input  wire logic [`FPU_SCHED_IDX_W-1:0] i_sched_index,
  input  wire logic [`FPU_RNID_W-1:0]      i_rnid,
  output logic                             o_valid,
  output noncomp_grp_e                     o_grp,
  output logic [1:0]                       o_mod,
  output logic [`FPU_SP_W-1:0]             o_a,
  output logic [`FPU_SP_W-1:0]             o_b,
  output fp_class_t                        o_a_class,
  output fp_class_t                        o_b_class,
  output logic [`FPU_SCHED_IDX_W-1:0]      o_sched_index,
  output logic [`FPU_RNID_W-1:0]           o_rnid
);

  logic                  w_legal;
  noncomp_grp_e          w_grp;
  logic [1:0]            w_mod;
  logic [`FPU_SP_W-1:0]  w_a;
  logic [`FPU_SP_W-1:0]  w_b;
  fp_class_t             w_a_class;
  fp_class_t             w_b_class;

  fpu_operand_class u_rs1_class (
    .i_reg   (i_rs1),
    .o_val   (w_a),
    .o_class (w_a_class)
  );

  fpu_operand_class u_rs2_class (
    .i_reg   (i_rs2),
    .o_val   (w_b),
    .o_class (w_b_class)
  );

  // mod: sgnj/n/x, min/max, eq/lt/le
  always_comb begin
    w_legal = 1'b1;
    w_grp   = GRP_SGNJ;
    w_mod   = 2'd0;
    case (i_op)
      OP_FSGNJ  : w_mod = 2'd0;
      OP_FSGNJN : w_mod = 2'd1;
      OP_FSGNJX : w_mod = 2'd2;
      OP_FMIN   : w_grp = GRP_MINMAX;
      OP_FMAX   : begin
        w_grp = GRP_MINMAX;
        w_mod = 2'd1;
      end
      OP_FEQ    : w_grp = GRP_CMP;
      OP_FLT    : begin
        w_grp = GRP_CMP;
        w_mod = 2'd1;
      end
      OP_FLE    : begin
        w_grp = GRP_CMP;
        w_mod = 2'd2;
      end
      OP_FCLASS : w_grp = GRP_CLASS;
      default   : w_legal = 1'b0; // dropped here, stage 2 never sees it
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid & w_legal;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_grp         <= w_grp;
      o_mod         <= w_mod;
      o_a           <= w_a;
      o_b           <= w_b;
      o_a_class     <= w_a_class;
      o_b_class     <= w_b_class;
      o_sched_index <= i_sched_index;
      o_rnid        <= i_rnid;
    end
  end

endmodule

`default_nettype wire

//--- source/fpu_exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fpu_exec_stage
  import fpu_noncomp_pkg::*;
(
  input  wire logic                        i_clk,
  input  wire logic                        i_rst_n,
  input  wire logic                        i_valid,
  input  wire noncomp_grp_e                i_grp,
  input  wire logic [1:0]                  i_mod,
  input  wire logic [`FPU_SP_W-1:0]        i_a,
  input  wire logic [`FPU_SP_W-1:0]        i_b,
  input  wire fp_class_t                   i_a_class,
  input  wire fp_class_t                   i_b_class,
  input  wire logic [`FPU_SCHED_IDX_W-1:0] i_sched_index,
  input  wire logic [`FPU_RNID_W-1:0]      i_rnid,
  output logic                             o_valid,
  output logic [`FPU_FLEN-1:0]             o_result,
  output logic [`FPU_FFLAGS_W-1:0]         o_fflags,
  output logic [`FPU_SCHED_IDX_W-1:0]      o_sched_index,
  output logic [`FPU_RNID_W-1:0]           o_rnid
);

  logic                     w_mag_lt;
  logic                     w_mag_gt;
  logic                     w_lt_total;
  logic                     w_both_zero;
  logic                     w_lt;
  logic                     w_eq;
  logic                     w_any_nan;
  logic                     w_any_snan;
  logic                     w_sgnj_sign;
  logic [`FPU_SP_W-1:0]     w_sgnj;
  logic [`FPU_SP_W-1:0]     w_minmax;
  logic                     w_cmp;
  logic [`FPU_CLASS_W-1:0]  w_class_mask;
  logic                     w_nv;
  logic [`FPU_FLEN-1:0]     w_result;

  // shared sign-magnitude comparator
  assign w_mag_lt    = i_a[30:0] < i_b[30:0];
  assign w_mag_gt    = i_a[30:0] > i_b[30:0];
  assign w_both_zero = i_a_class.is_zero & i_b_class.is_zero;

  // -0 orders below +0 here, used as is by min/max
  assign w_lt_total = (i_a_class.sign != i_b_class.sign) ? i_a_class.sign :
                      i_a_class.sign ? w_mag_gt : w_mag_lt;

  assign w_lt = w_lt_total & ~w_both_zero; // zeros compare equal
  assign w_eq = (i_a == i_b) | w_both_zero;

  assign w_any_nan  = i_a_class.is_nan | i_b_class.is_nan;
  assign w_any_snan = i_a_class.is_snan | i_b_class.is_snan;

  always_comb begin
    case (i_mod)
      2'd0    : w_sgnj_sign = i_b_class.sign;
      2'd1    : w_sgnj_sign = ~i_b_class.sign;
      default : w_sgnj_sign = i_a_class.sign ^ i_b_class.sign;
    endcase
  end

  assign w_sgnj = {w_sgnj_sign, i_a[30:0]};

  always_comb begin
    if (i_a_class.is_nan & i_b_class.is_nan) begin
      w_minmax = `FPU_CANON_NAN;
    end else if (i_a_class.is_nan) begin
      w_minmax = i_b;
    end else if (i_b_class.is_nan) begin
      w_minmax = i_a;
    end else if (i_mod[0]) begin
      w_minmax = w_lt_total ? i_b : i_a; // max
    end else begin
      w_minmax = w_lt_total ? i_a : i_b; // min
    end
  end

  always_comb begin
    case (i_mod)
      2'd0    : w_cmp = w_eq;
      2'd1    : w_cmp = w_lt;
      default : w_cmp = w_lt | w_eq;
    endcase
    if (w_any_nan) begin
      w_cmp = 1'b0; // unordered
    end
  end

  assign w_class_mask[0] = i_a_class.sign & i_a_class.is_inf;
  assign w_class_mask[1] = i_a_class.sign & i_a_class.is_normal;
  assign w_class_mask[2] = i_a_class.sign & i_a_class.is_subnormal;
  assign w_class_mask[3] = i_a_class.sign & i_a_class.is_zero;
  assign w_class_mask[4] = ~i_a_class.sign & i_a_class.is_zero;
  assign w_class_mask[5] = ~i_a_class.sign & i_a_class.is_subnormal;
  assign w_class_mask[6] = ~i_a_class.sign & i_a_class.is_normal;
  assign w_class_mask[7] = ~i_a_class.sign & i_a_class.is_inf;
  assign w_class_mask[8] = i_a_class.is_snan;
  assign w_class_mask[9] = i_a_class.is_qnan;

  always_comb begin
    case (i_grp)
      GRP_SGNJ : begin
        w_result = {{(`FPU_FLEN-`FPU_SP_W){1'b1}}, w_sgnj};
        w_nv     = 1'b0;
      end
      GRP_MINMAX : begin
        w_result = {{(`FPU_FLEN-`FPU_SP_W){1'b1}}, w_minmax};
        w_nv     = w_any_snan;
      end
      GRP_CMP : begin
        w_result = {{(`FPU_FLEN-1){1'b0}}, w_cmp};
        w_nv     = (i_mod == 2'd0) ? w_any_snan : w_any_nan; // feq is quiet
      end
      default : begin
        w_result = {{(`FPU_FLEN-`FPU_CLASS_W){1'b0}}, w_class_mask};
        w_nv     = 1'b0;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid       <= 1'b0;
      o_result      <= '0;
      o_fflags      <= '0;
      o_sched_index <= '0;
      o_rnid        <= '0;
    end else if (i_valid) begin
      o_valid       <= 1'b1;
      o_result      <= w_result;
      o_fflags      <= {w_nv, {(`FPU_FFLAGS_W-1){1'b0}}}; // nv only
      o_sched_index <= i_sched_index;
      o_rnid        <= i_rnid;
    end else begin
      o_valid       <= 1'b0; // outputs idle at zero
      o_result      <= '0;
      o_fflags      <= '0;
      o_sched_index <= '0;
      o_rnid        <= '0;
    end
  end

endmodule

`default_nettype wire

//--- source/fpu_noncomp_pkg.sv
`default_nettype none

package fpu_noncomp_pkg;

  typedef enum logic [3:0] {
    OP_FSGNJ  = 4'd0,
    OP_FSGNJN = 4'd1,
    OP_FSGNJX = 4'd2,
    OP_FMIN   = 4'd3,
    OP_FMAX   = 4'd4,
    OP_FEQ    = 4'd5,
    OP_FLT    = 4'd6,
    OP_FLE    = 4'd7,
    OP_FCLASS = 4'd8 // 9..15 illegal
  } fpu_op_e;

  typedef enum logic [1:0] {
    GRP_SGNJ   = 2'd0,
    GRP_MINMAX = 2'd1,
    GRP_CMP    = 2'd2,
    GRP_CLASS  = 2'd3
  } noncomp_grp_e;

  // per-operand class bits, filled by fpu_operand_class
  typedef struct packed {
    logic sign;
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_snan;
    logic is_qnan;
    logic spare;
  } fp_class_t;

endpackage

`default_nettype wire

//--- source/fpu_noncomp_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fpu_noncomp_unit
  import fpu_noncomp_pkg::*;
(
  input  wire logic                        i_clk,
  input  wire logic                        i_rst_n,
  input  wire logic                        i_valid,
  input  wire fpu_op_e                     i_op,
  input  wire logic [`FPU_FLEN-1:0]        i_rs1,
  input  wire logic [`FPU_FLEN-1:0]        i_rs2,
  input  wire logic [`FPU_SCHED_IDX_W-1:0] i_sched_index,
  input  wire logic [`FPU_RNID_W-1:0]      i_rnid,
  output logic                             o_valid,
  output logic [`FPU_FLEN-1:0]             o_result,
  output logic [`FPU_FFLAGS_W-1:0]         o_fflags,
  output logic [`FPU_SCHED_IDX_W-1:0]      o_sched_index,
  output logic [`FPU_RNID_W-1:0]           o_rnid
);

  logic                         s1_valid;
  noncomp_grp_e                 s1_grp;
  logic [1:0]                   s1_mod;
  logic [`FPU_SP_W-1:0]         s1_a;
  logic [`FPU_SP_W-1:0]         s1_b;
  fp_class_t                    s1_a_class;
  fp_class_t                    s1_b_class;
  logic [`FPU_SCHED_IDX_W-1:0]  s1_sched_index;
  logic [`FPU_RNID_W-1:0]       s1_rnid;

  fpu_decode_stage u_decode (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_valid       (i_valid),
    .i_op          (i_op),
    .i_rs1         (i_rs1),
    .i_rs2         (i_rs2),
    .i_sched_index (i_sched_index),
    .i_rnid        (i_rnid),
    .o_valid       (s1_valid),
    .o_grp         (s1_grp),
    .o_mod         (s1_mod),
    .o_a           (s1_a),
    .o_b           (s1_b),
    .o_a_class     (s1_a_class),
    .o_b_class     (s1_b_class),
    .o_sched_index (s1_sched_index),
    .o_rnid        (s1_rnid)
  );

  fpu_exec_stage u_exec (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_valid       (s1_valid),
    .i_grp         (s1_grp),
    .i_mod         (s1_mod),
    .i_a           (s1_a),
    .i_b           (s1_b),
    .i_a_class     (s1_a_class),
    .i_b_class     (s1_b_class),
    .i_sched_index (s1_sched_index),
    .i_rnid        (s1_rnid),
    .o_valid       (o_valid),
    .o_result      (o_result),
    .o_fflags      (o_fflags),
    .o_sched_index (o_sched_index),
    .o_rnid        (o_rnid)
  );

endmodule

`default_nettype wire

//--- source/fpu_operand_class.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fpu_operand_class
  import fpu_noncomp_pkg::*;
(
  input  wire logic [`FPU_FLEN-1:0] i_reg,
  output logic [`FPU_SP_W-1:0]      o_val,
  output fp_class_t                 o_class
);

  logic        w_boxed;
  logic [7:0]  w_exp;
  logic [22:0] w_man;
  logic        w_exp_ones;
  logic        w_exp_zero;
  logic        w_man_zero;

  assign w_boxed = &i_reg[`FPU_FLEN-1:`FPU_SP_W];
  assign o_val   = w_boxed ? i_reg[`FPU_SP_W-1:0] : `FPU_CANON_NAN; // bad box reads as qnan

  assign w_exp = o_val[30:23];
  assign w_man = o_val[22:0];

  assign w_exp_ones = &w_exp;
  assign w_exp_zero = ~|w_exp;
  assign w_man_zero = ~|w_man;

  always_comb begin
    o_class              = '0;
    o_class.sign         = o_val[31];
    o_class.is_zero      = w_exp_zero & w_man_zero;
    o_class.is_subnormal = w_exp_zero & ~w_man_zero;
    o_class.is_normal    = ~w_exp_zero & ~w_exp_ones;
    o_class.is_inf       = w_exp_ones & w_man_zero;
    o_class.is_nan       = w_exp_ones & ~w_man_zero;
    o_class.is_snan      = w_exp_ones & ~w_man_zero & ~w_man[22]; // quiet bit clear
    o_class.is_qnan      = w_exp_ones & w_man[22];
    o_class.spare        = 1'b0;
  end

endmodule

`default_nettype wire

//--- verif/fpu_noncomp_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fpu_noncomp_checker
  import fpu_noncomp_pkg::*;
(
  input wire logic                        i_clk,
  input wire logic                        i_rst_n,
  input wire logic                        i_valid,
  input wire logic [`FPU_FLEN-1:0]        i_result,
  input wire logic [`FPU_FFLAGS_W-1:0]    i_fflags,
  input wire logic [`FPU_SCHED_IDX_W-1:0] i_sched_index,
  input wire logic [`FPU_RNID_W-1:0]      i_rnid
);

  typedef struct packed {
    logic [31:0]                 due; // cycle the result must show up
    logic [`FPU_FLEN-1:0]        res;
    logic [`FPU_FFLAGS_W-1:0]    fl;
    logic [`FPU_SCHED_IDX_W-1:0] sidx;
    logic [`FPU_RNID_W-1:0]      rnid;
  } exp_t;

  exp_t        pend[$];
  exp_t        head;
  int unsigned cyc = 0;
  int          errors = 0;
  int          checked = 0;

  function automatic int pending();
    return pend.size();
  endfunction

  function automatic logic [31:0] unbox(input logic [63:0] r);
    return (r[63:32] == 32'hffffffff) ? r[31:0] : `FPU_CANON_NAN;
  endfunction

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 0);
  endfunction

  // maps a float onto an unsigned total order with -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h80000000);
  endfunction

  function automatic logic [9:0] class_mask(input logic [31:0] x);
    logic e_ones;
    logic e_zero;
    logic m_zero;
    e_ones = (x[30:23] == 8'hff);
    e_zero = (x[30:23] == 8'h00);
    m_zero = (x[22:0] == 0);
    if (e_ones && !m_zero) return x[22] ? 10'h200 : 10'h100;
    if (e_ones) return x[31] ? 10'h001 : 10'h080;
    if (e_zero && m_zero) return x[31] ? 10'h008 : 10'h010;
    if (e_zero) return x[31] ? 10'h004 : 10'h020;
    return x[31] ? 10'h002 : 10'h040;
  endfunction

  task automatic predict(input logic [3:0] op, input logic [63:0] rs1, input logic [63:0] rs2,
                         output logic [63:0] res, output logic [4:0] fl);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pick;
    logic        any_nan;
    logic        any_snan;
    logic        zeros;
    logic        lt;
    logic        eq;
    a        = unbox(rs1);
    b        = unbox(rs2);
    any_nan  = is_nan(a) | is_nan(b);
    any_snan = (is_nan(a) & ~a[22]) | (is_nan(b) & ~b[22]);
    zeros    = (a[30:0] == 0) && (b[30:0] == 0);
    lt       = (order_key(a) < order_key(b)) && !zeros;
    eq       = (a == b) || zeros;
    res      = '0;
    fl       = '0;
    case (op)
      OP_FSGNJ  : res = {32'hffffffff, b[31], a[30:0]};
      OP_FSGNJN : res = {32'hffffffff, ~b[31], a[30:0]};
      OP_FSGNJX : res = {32'hffffffff, a[31] ^ b[31], a[30:0]};
      OP_FMIN, OP_FMAX : begin
        if (is_nan(a) && is_nan(b)) pick = `FPU_CANON_NAN;
        else if (is_nan(a)) pick = b;
        else if (is_nan(b)) pick = a;
        else if ((order_key(a) < order_key(b)) == (op == OP_FMIN)) pick = a;
        else pick = b;
        res   = {32'hffffffff, pick};
        fl[4] = any_snan;
      end
      OP_FEQ : begin
        res[0] = eq & ~any_nan;
        fl[4]  = any_snan; // quiet compare
      end
      OP_FLT : begin
        res[0] = lt & ~any_nan;
        fl[4]  = any_nan;
      end
      OP_FLE : begin
        res[0] = (lt | eq) & ~any_nan;
        fl[4]  = any_nan;
      end
      default : res[9:0] = class_mask(a);
    endcase
  endtask

  // called 2 ns after the edge before the accepting one
  task automatic expect_result(input logic [63:0] res, input logic [4:0] fl,
                               input logic [2:0] sidx, input logic [5:0] rnid);
    exp_t e;
    e.due  = cyc + 2;
    e.res  = res;
    e.fl   = fl;
    e.sidx = sidx;
    e.rnid = rnid;
    pend.push_back(e);
  endtask

  task automatic expect_op(input logic [3:0] op, input logic [63:0] rs1, input logic [63:0] rs2,
                           input logic [2:0] sidx, input logic [5:0] rnid);
    logic [63:0] res;
    logic [4:0]  fl;
    predict(op, rs1, rs2, res, fl);
    expect_result(res, fl, sidx, rnid);
  endtask

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
      errors++;
      $display("Fail %s expected %0h got %0h at cycle %0d", name, exp, got, cyc);
    end
  endtask

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
  end

  // sample mid cycle once the outputs have settled
  always @(negedge i_clk) begin
    if (i_rst_n !== 1'b1) begin
      if (cyc > 0 && i_valid !== 1'b0) begin
        errors++;
        $display("o_valid is not low during reset at cycle %0d", cyc);
      end
    end else if (pend.size() > 0 && pend[0].due == cyc) begin
      head = pend.pop_front();
      checked++;
      if (i_valid !== 1'b1) begin
        errors++;
        $display("no result on the outputs at cycle %0d where one was due", cyc);
      end else begin
        compare("o_result", head.res, i_result);
        compare("o_fflags", head.fl, i_fflags);
        compare("o_sched_index", head.sidx, i_sched_index);
        compare("o_rnid", head.rnid, i_rnid);
      end
    end else if (i_valid !== 1'b0) begin
      errors++;
      $display("o_valid is high at cycle %0d with no result expected", cyc);
    end else if (i_result !== '0 || i_fflags !== '0 || i_sched_index !== '0 || i_rnid !== '0) begin
      errors++;
      $display("output data is not zero while o_valid is low at cycle %0d", cyc);
    end
  end

endmodule

`default_nettype wire

//--- verif/fpu_noncomp_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fpu_noncomp_props
  import fpu_noncomp_pkg::*;
(
  input wire logic                     i_clk,
  input wire logic                     i_rst_n,
  input wire logic                     i_valid,
  input wire logic [3:0]               i_op,
  input wire logic                     i_res_valid,
  input wire logic [`FPU_FFLAGS_W-1:0] i_fflags
);

  logic        w_accept;
  int unsigned fails = 0;

  assign w_accept = i_rst_n & i_valid & (i_op <= OP_FCLASS); // legal codes only

  a_latency : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_res_valid == $past(w_accept, 2))
    else begin
      $error("o_valid does not follow an accepted operation by two cycles");
      fails++;
    end

  a_nv_only : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_fflags[`FPU_FFLAGS_W-2:0] == '0)
    else begin
      $error("o_fflags has a bit other than NV set");
      fails++;
    end

  a_reset : assert property (@(posedge i_clk) !i_rst_n |=> !i_res_valid)
    else begin
      $error("o_valid is high during reset");
      fails++;
    end

endmodule

bind fpu_noncomp_unit fpu_noncomp_props u_props (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_valid     (i_valid),
  .i_op        (i_op),
  .i_res_valid (o_valid),
  .i_fflags    (o_fflags)
);

`default_nettype wire

//--- verif/fpu_noncomp_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fpu_noncomp_tb
  import fpu_noncomp_pkg::*;
();

  typedef struct packed {
    logic [3:0]               op;
    logic [`FPU_FLEN-1:0]     rs1;
    logic [`FPU_FLEN-1:0]     rs2;
    logic [`FPU_FLEN-1:0]     res;
    logic [`FPU_FFLAGS_W-1:0] fl;
    logic [1:0]               gap; // idle cycles after the entry
  } row_t;

  logic                        clk;
  logic                        rst_n;
  logic                        valid;
  fpu_op_e                     op;
  logic [`FPU_FLEN-1:0]        rs1;
  logic [`FPU_FLEN-1:0]        rs2;
  logic [`FPU_SCHED_IDX_W-1:0] sidx;
  logic [`FPU_RNID_W-1:0]      rnid;
  logic                        out_valid;
  logic [`FPU_FLEN-1:0]        out_result;
  logic [`FPU_FFLAGS_W-1:0]    out_fflags;
  logic [`FPU_SCHED_IDX_W-1:0] out_sidx;
  logic [`FPU_RNID_W-1:0]      out_rnid;

  row_t        tbl[$];
  logic [8:0]  tag_cnt;
  logic [15:0] lfsr;
  int          opnd_cnt;
  int          errors;

  fpu_noncomp_unit uut (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_valid       (valid),
    .i_op          (op),
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_sched_index (sidx),
    .i_rnid        (rnid),
    .o_valid       (out_valid),
    .o_result      (out_result),
    .o_fflags      (out_fflags),
    .o_sched_index (out_sidx),
    .o_rnid        (out_rnid)
  );

  fpu_noncomp_checker u_chk (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_valid       (out_valid),
    .i_result      (out_result),
    .i_fflags      (out_fflags),
    .i_sched_index (out_sidx),
    .i_rnid        (out_rnid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [63:0] bx(input logic [31:0] x);
    return {32'hffffffff, x};
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic rand_operand(output logic [63:0] r);
    logic [63:0] v;
    draw_bits(34, v);
    r = bx(v[31:0]);
    if (v[33:32] == 2'd0) begin
      r[30:23] = 8'hff; // inf or nan
    end else if (v[33:32] == 2'd1) begin
      r[30:23] = 8'h00; // zero or subnormal
    end
    opnd_cnt++;
    if (opnd_cnt % 10 == 0) begin
      draw_bits(32, v);
      r[63:32] = v[31:0] & 32'hfffeffff; // broken box
    end
  endtask

  task automatic add_row(input logic [3:0] o, input logic [63:0] a, input logic [63:0] b,
                         input logic [63:0] res, input logic [4:0] fl, input logic [1:0] gap);
    row_t r;
    r.op  = o;
    r.rs1 = a;
    r.rs2 = b;
    r.res = res;
    r.fl  = fl;
    r.gap = gap;
    tbl.push_back(r);
  endtask

  task automatic load_table();
    add_row(OP_FSGNJ, bx(32'h3f800000), bx(32'hc0000000), bx(32'hbf800000), 5'h00, 0);
    add_row(OP_FSGNJN, bx(32'h3f800000), bx(32'hc0000000), bx(32'h3f800000), 5'h00, 0);
    add_row(OP_FSGNJX, bx(32'hbf800000), bx(32'hc0000000), bx(32'h3f800000), 5'h00, 1);
    add_row(OP_FSGNJ, 64'h00000000_3f800000, bx(32'hc0000000), bx(32'hffc00000), 5'h00, 0);
    add_row(OP_FSGNJN, bx(32'hbf800000), 64'h12345678_00000000, bx(32'hbf800000), 5'h00, 0);
    add_row(OP_FSGNJX, 64'h0, bx(32'hbf800000), bx(32'hffc00000), 5'h00, 2);
    add_row(OP_FMIN, bx(32'h00000000), bx(32'h80000000), bx(32'h80000000), 5'h00, 0);
    add_row(OP_FMAX, bx(32'h00000000), bx(32'h80000000), bx(32'h00000000), 5'h00, 0);
    add_row(4'd9, bx(32'h3f800000), bx(32'h40000000), 64'h0, 5'h00, 0); // illegal
    add_row(OP_FMIN, bx(32'h7fc00000), bx(32'h3f800000), bx(32'h3f800000), 5'h00, 0);
    add_row(OP_FMAX, bx(32'hc0000000), bx(32'h7f800001), bx(32'hc0000000), 5'h10, 0);
    add_row(OP_FMIN, bx(32'h7fc00000), bx(32'h7f800001), bx(32'h7fc00000), 5'h10, 1);
    add_row(OP_FMAX, bx(32'h7fc00000), bx(32'h7fc00000), bx(32'h7fc00000), 5'h00, 0);
    add_row(OP_FMIN, bx(32'hbf800000), bx(32'hc0000000), bx(32'hc0000000), 5'h00, 0);
    add_row(OP_FMAX, bx(32'h3f800000), bx(32'h40000000), bx(32'h40000000), 5'h00, 3);
    add_row(OP_FLT, bx(32'h3f800000), bx(32'h40000000), 64'h1, 5'h00, 0);
    add_row(OP_FLT, bx(32'h40000000), bx(32'h3f800000), 64'h0, 5'h00, 0);
    add_row(OP_FLE, bx(32'hc0000000), bx(32'hbf800000), 64'h1, 5'h00, 0);
    add_row(OP_FEQ, bx(32'h00000000), bx(32'h80000000), 64'h1, 5'h00, 0);
    add_row(4'd15, bx(32'h7f800001), bx(32'h7f800001), 64'h0, 5'h00, 0); // illegal
    add_row(OP_FLE, bx(32'h80000000), bx(32'h00000000), 64'h1, 5'h00, 0);
    add_row(OP_FLT, bx(32'h80000000), bx(32'h00000000), 64'h0, 5'h00, 1);
    add_row(OP_FEQ, bx(32'h7fc00000), bx(32'h3f800000), 64'h0, 5'h00, 0);
    add_row(OP_FEQ, bx(32'h7f800001), bx(32'h3f800000), 64'h0, 5'h10, 0);
    add_row(OP_FLT, bx(32'h7fc00000), bx(32'h3f800000), 64'h0, 5'h10, 0);
    add_row(OP_FLE, bx(32'h3f800000), bx(32'h7f800001), 64'h0, 5'h10, 0);
    add_row(OP_FEQ, bx(32'h3f800000), bx(32'h3f800000), 64'h1, 5'h00, 2);
    add_row(OP_FCLASS, bx(32'hff800000), bx(32'h0), 64'h001, 5'h00, 0);
    add_row(OP_FCLASS, bx(32'hbf800000), bx(32'h0), 64'h002, 5'h00, 0);
    add_row(OP_FCLASS, bx(32'h80000001), bx(32'h0), 64'h004, 5'h00, 0);
    add_row(OP_FCLASS, bx(32'h80000000), bx(32'h0), 64'h008, 5'h00, 0);
    add_row(OP_FCLASS, bx(32'h00000000), bx(32'h0), 64'h010, 5'h00, 0);
    add_row(OP_FCLASS, bx(32'h00000001), bx(32'h0), 64'h020, 5'h00, 0);
    add_row(OP_FCLASS, bx(32'h3f800000), bx(32'h0), 64'h040, 5'h00, 0);
    add_row(OP_FCLASS, bx(32'h7f800000), bx(32'h0), 64'h080, 5'h00, 0);
    add_row(OP_FCLASS, bx(32'h7f800001), bx(32'h0), 64'h100, 5'h00, 0);
    add_row(OP_FCLASS, bx(32'h7fc00000), bx(32'h0), 64'h200, 5'h00, 0);
    add_row(OP_FCLASS, 64'h0000ffff_00000000, bx(32'h0), 64'h200, 5'h00, 1);
  endtask

  task automatic issue(input logic [3:0] o, input logic [63:0] a, input logic [63:0] b);
    @(posedge clk);
    #2;
    valid = 1'b1;
    op    = fpu_op_e'(o);
    rs1   = a;
    rs2   = b;
    sidx  = tag_cnt[2:0];
    rnid  = tag_cnt[8:3];
    tag_cnt++;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (u_chk.pending() > 0 && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (u_chk.pending() > 0) begin
      errors++;
      $display("timeout with %0d results still outstanding", u_chk.pending());
    end
  endtask

  initial begin
    logic [63:0] v;
    logic [63:0] a;
    logic [63:0] b;
    logic [3:0]  rop;
    rst_n    = 1'b0;
    valid    = 1'b0;
    op       = OP_FSGNJ;
    rs1      = '0;
    rs2      = '0;
    sidx     = '0;
    rnid     = '0;
    tag_cnt  = 9'd5;
    lfsr     = 16'd55447;
    opnd_cnt = 0;
    errors   = 0;
    load_table();
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (3) idle_cycle(); // output must stay quiet
    for (int i = 0; i < tbl.size(); i++) begin
      issue(tbl[i].op, tbl[i].rs1, tbl[i].rs2);
      if (tbl[i].op <= OP_FCLASS) begin
        u_chk.expect_result(tbl[i].res, tbl[i].fl, sidx, rnid);
      end
      repeat (tbl[i].gap) idle_cycle();
    end
    for (int n = 0; n < 80; n++) begin
      draw_bits(6, v);
      rop = v[3:0] % 9;
      rand_operand(a);
      if (v[5:4] == 2'd0) begin
        b = a; // equal operands
      end else begin
        rand_operand(b);
      end
      issue(rop, a, b);
      u_chk.expect_op(rop, a, b, sidx, rnid);
      if (v[5:4] == 2'd3) begin
        idle_cycle();
      end
    end
    idle_cycle();
    wait_drain();
    repeat (3) @(posedge clk);
    $display("checked %0d results, %0d mismatches, %0d other errors, %0d assertion failures",
             u_chk.checked, u_chk.errors, errors, uut.u_props.fails);
    if (u_chk.errors == 0 && errors == 0 && uut.u_props.fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
